// File: cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  // Operations the controller knows; any other opcode byte becomes OP_NOP
  typedef enum logic [5:0] {
    OP_NOP,
    OP_LDA,
    OP_LDX,
    OP_LDY,
    OP_STA,
    OP_STX,
    OP_STY,
    OP_ADC,
    OP_SBC,
    OP_AND,
    OP_ORA,
    OP_EOR,
    OP_CMP,
    OP_CPX,
    OP_CPY,
    OP_INX,
    OP_INY,
    OP_DEX,
    OP_DEY,
    OP_TAX,
    OP_TAY,
    OP_TXA,
    OP_TYA,
    OP_TSX,
    OP_TXS,
    OP_SEC,
    OP_SED,
    OP_SEI,
    OP_CLC,
    OP_CLD,
    OP_CLI,
    OP_CLV,
    OP_BCC,
    OP_BCS,
    OP_BNE,
    OP_BEQ,
    OP_BVC,
    OP_BVS,
    OP_BPL,
    OP_BMI,
    OP_JMP
  } op_t;

  typedef enum logic [3:0] {
    AM_IMP,
    AM_IMM,
    AM_ZPG,
    AM_ZPX,
    AM_ZPY,
    AM_ABS,
    AM_REL
  } addr_mode_t;

  // Timing states of the sequencer
  typedef enum logic [3:0] {
    T0_R_OPCO,
    T1_R_OPER,
    T2_ABS_AM,
    T2_ZPR_AM,
    T2_REL_AM,
    T3_REL_AM,
    TX_R_DATA,
    TX_W_DATA
  } state_t;

  typedef struct packed {
    op_t        op;
    addr_mode_t addr_mode;
  } decoded_t;

  typedef struct packed {
    logic is_ldr;
    logic is_str;
    logic is_txr;
    logic is_set;
    logic is_clr;
  } op_class_t;

  // Bit positions in the 9-bit flag vector
  localparam int FLAG_C   = 0;
  localparam int FLAG_Z   = 1;
  localparam int FLAG_I   = 2;
  localparam int FLAG_D   = 3;
  localparam int FLAG_V   = 6;
  localparam int FLAG_N   = 7;
  localparam int FLAG_PCC = 8;

endpackage

// File: cpu_ctrl_word_pkg.sv
package cpu_ctrl_word_pkg;

  // Read is the high level of the R/W line
  typedef enum logic {
    RW_W = 1'b0,
    RW_R = 1'b1
  } rw_t;

  typedef enum logic [2:0] {DB_A, DB_X, DB_Y} db_out_src_t;

  typedef enum logic [2:0] {
    REG_SRC_MEM,
    REG_SRC_T,
    REG_SRC_A,
    REG_SRC_X,
    REG_SRC_Y,
    REG_SRC_S,
    REG_SRC_ALU
  } reg_src_t;

  typedef enum logic [2:0] {REG_DST_T, REG_DST_A, REG_DST_X, REG_DST_Y, REG_DST_S} reg_dst_t;

  // ALU_THA passes operand A through unchanged
  typedef enum logic [3:0] {
    ALU_THA,
    ALU_ADC,
    ALU_SBC,
    ALU_AND,
    ALU_ORA,
    ALU_EOR,
    ALU_CMP,
    ALU_INC,
    ALU_DEC
  } alu_op_t;

  typedef enum logic [2:0] {ALU_SRC_A_A, ALU_SRC_A_X, ALU_SRC_A_Y} alu_src_a_t;
  typedef enum logic {ALU_SRC_B_T, ALU_SRC_B_H00} alu_src_b_t;
  typedef enum logic [2:0] {P_SRC_ALU, P_SRC_SET, P_SRC_CLR} p_src_t;

  // CADD adds the carry left over from the PCL adder into PCH
  typedef enum logic [1:0] {PCADDER_NOP, PCADDER_INC, PCADDER_ADD, PCADDER_CADD} pcadder_t;

  typedef enum logic [1:0] {PCL_SRC_ADD, PCL_SRC_T, PCL_SRC_MEM} pcl_src_t;
  typedef enum logic {PCH_SRC_ADD, PCH_SRC_MEM} pch_src_t;

  // PCN is the next PC, PCC the current one
  typedef enum logic [2:0] {ABL_SRC_PCN, ABL_SRC_PCC, ABL_SRC_MEM, ABL_SRC_T, ABL_SRC_ALU} abl_src_t;
  typedef enum logic [2:0] {ABH_SRC_PCN, ABH_SRC_PCC, ABH_SRC_MEM, ABH_SRC_H00} abh_src_t;

  typedef struct packed {
    rw_t         r_w;
    db_out_src_t db_out_src;
  } bus_ctrl_t;

  typedef struct packed {
    reg_src_t reg_src;
    logic     a_we;
    logic     x_we;
    logic     y_we;
    logic     s_we;
    logic     t_we;
  } reg_ctrl_t;

  typedef struct packed {
    alu_op_t    alu_op;
    alu_src_a_t src_a;
    alu_src_b_t src_b;
  } alu_ctrl_t;

  typedef struct packed {
    p_src_t     p_src;
    logic [7:0] p_mask;
    logic       p_we;
  } p_ctrl_t;

  typedef struct packed {
    pcadder_t pcadder;
    pcl_src_t pcl_src;
    pch_src_t pch_src;
    logic     pcl_we;
    logic     pch_we;
  } pc_ctrl_t;

  typedef struct packed {
    abl_src_t abl_src;
    abh_src_t abh_src;
    logic     abl_we;
    logic     abh_we;
  } ab_ctrl_t;

  typedef struct packed {
    bus_ctrl_t bus;
    logic      ir_we;
    reg_ctrl_t rf;
    alu_ctrl_t alu;
    p_ctrl_t   p;
    pc_ctrl_t  pc;
    ab_ctrl_t  ab;
  } ctrl_word_t;

endpackage

// File: instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import cpu_ctrl_pkg::*; (
  input  logic [7:0] instr,
  output decoded_t   dec
);

  op_t        grp_op;
  addr_mode_t grp_mode;
  logic       grp_ok;

  // Group one opcodes (cc = 01) decode from their aaa and bbb fields
  always_comb begin
    case (instr[7:5])
      3'b000:  grp_op = OP_ORA;
      3'b001:  grp_op = OP_AND;
      3'b010:  grp_op = OP_EOR;
      3'b011:  grp_op = OP_ADC;
      3'b100:  grp_op = OP_STA;
      3'b101:  grp_op = OP_LDA;
      3'b110:  grp_op = OP_CMP;
      default: grp_op = OP_SBC;
    endcase
    grp_ok = 1'b1;
    case (instr[4:2])
      3'b001:  grp_mode = AM_ZPG;
      3'b010:  grp_mode = AM_IMM;
      3'b011:  grp_mode = AM_ABS;
      3'b101:  grp_mode = AM_ZPX;
      default: begin
        // Indexed absolute and indirect forms are not supported
        grp_mode = AM_IMP;
        grp_ok = 1'b0;
      end
    endcase
    // STA has no immediate form
    if (grp_op == OP_STA && grp_mode == AM_IMM)
      grp_ok = 1'b0;
  end

  always_comb begin
    dec = '{OP_NOP, AM_IMP};
    if (instr[1:0] == 2'b01) begin
      if (grp_ok)
        dec = '{grp_op, grp_mode};
    end else begin
      case (instr)
        8'hA2: dec = '{OP_LDX, AM_IMM};
        8'hA6: dec = '{OP_LDX, AM_ZPG};
        8'hB6: dec = '{OP_LDX, AM_ZPY};
        8'hAE: dec = '{OP_LDX, AM_ABS};
        8'hA0: dec = '{OP_LDY, AM_IMM};
        8'hA4: dec = '{OP_LDY, AM_ZPG};
        8'hB4: dec = '{OP_LDY, AM_ZPX};
        8'hAC: dec = '{OP_LDY, AM_ABS};
        8'h86: dec = '{OP_STX, AM_ZPG};
        8'h96: dec = '{OP_STX, AM_ZPY};
        8'h8E: dec = '{OP_STX, AM_ABS};
        8'h84: dec = '{OP_STY, AM_ZPG};
        8'h94: dec = '{OP_STY, AM_ZPX};
        8'h8C: dec = '{OP_STY, AM_ABS};
        8'hE0: dec = '{OP_CPX, AM_IMM};
        8'hE4: dec = '{OP_CPX, AM_ZPG};
        8'hEC: dec = '{OP_CPX, AM_ABS};
        8'hC0: dec = '{OP_CPY, AM_IMM};
        8'hC4: dec = '{OP_CPY, AM_ZPG};
        8'hCC: dec = '{OP_CPY, AM_ABS};
        8'hE8: dec = '{OP_INX, AM_IMP};
        8'hC8: dec = '{OP_INY, AM_IMP};
        8'hCA: dec = '{OP_DEX, AM_IMP};
        8'h88: dec = '{OP_DEY, AM_IMP};
        8'hAA: dec = '{OP_TAX, AM_IMP};
        8'hA8: dec = '{OP_TAY, AM_IMP};
        8'h8A: dec = '{OP_TXA, AM_IMP};
        8'h98: dec = '{OP_TYA, AM_IMP};
        8'hBA: dec = '{OP_TSX, AM_IMP};
        8'h9A: dec = '{OP_TXS, AM_IMP};
        8'h38: dec = '{OP_SEC, AM_IMP};
        8'hF8: dec = '{OP_SED, AM_IMP};
        8'h78: dec = '{OP_SEI, AM_IMP};
        8'h18: dec = '{OP_CLC, AM_IMP};
        8'hD8: dec = '{OP_CLD, AM_IMP};
        8'h58: dec = '{OP_CLI, AM_IMP};
        8'hB8: dec = '{OP_CLV, AM_IMP};
        8'h90: dec = '{OP_BCC, AM_REL};
        8'hB0: dec = '{OP_BCS, AM_REL};
        8'hD0: dec = '{OP_BNE, AM_REL};
        8'hF0: dec = '{OP_BEQ, AM_REL};
        8'h50: dec = '{OP_BVC, AM_REL};
        8'h70: dec = '{OP_BVS, AM_REL};
        8'h10: dec = '{OP_BPL, AM_REL};
        8'h30: dec = '{OP_BMI, AM_REL};
        8'h4C: dec = '{OP_JMP, AM_ABS};
        default: dec = '{OP_NOP, AM_IMP};
      endcase
    end
  end

endmodule

// File: op_classifier.sv
`timescale 1ns/1ps

module op_classifier import cpu_ctrl_pkg::*, cpu_ctrl_word_pkg::*; (
  input  decoded_t   dec,
  input  logic [8:0] flags,
  output op_class_t  cls,
  output reg_src_t   mov_src,
  output reg_dst_t   mov_dst,
  output alu_op_t    exe_op,
  output alu_src_a_t exe_src_a,
  output logic [7:0] flag_mask,
  output logic       branch_taken
);

  op_t op;

  assign op = dec.op;

  assign cls.is_ldr = (op == OP_LDA) || (op == OP_LDX) || (op == OP_LDY);
  assign cls.is_str = (op == OP_STA) || (op == OP_STX) || (op == OP_STY);
  assign cls.is_txr = (op == OP_TAX) || (op == OP_TAY) || (op == OP_TXA) ||
                      (op == OP_TYA) || (op == OP_TSX) || (op == OP_TXS);
  assign cls.is_set = (op == OP_SEC) || (op == OP_SED) || (op == OP_SEI);
  assign cls.is_clr = (op == OP_CLC) || (op == OP_CLD) || (op == OP_CLI) || (op == OP_CLV);

  // Loads take their data from T, which holds the operand or memory byte
  always_comb begin
    case (op)
      OP_TAX, OP_TAY: mov_src = REG_SRC_A;
      OP_TXA, OP_TXS: mov_src = REG_SRC_X;
      OP_TYA:         mov_src = REG_SRC_Y;
      OP_TSX:         mov_src = REG_SRC_S;
      default:        mov_src = REG_SRC_T;
    endcase
    case (op)
      OP_LDA, OP_TXA, OP_TYA: mov_dst = REG_DST_A;
      OP_LDX, OP_TAX, OP_TSX: mov_dst = REG_DST_X;
      OP_LDY, OP_TAY:         mov_dst = REG_DST_Y;
      OP_TXS:                 mov_dst = REG_DST_S;
      default:                mov_dst = REG_DST_T;
    endcase
  end

  always_comb begin
    case (op)
      OP_ADC:                 exe_op = ALU_ADC;
      OP_SBC:                 exe_op = ALU_SBC;
      OP_AND:                 exe_op = ALU_AND;
      OP_ORA:                 exe_op = ALU_ORA;
      OP_EOR:                 exe_op = ALU_EOR;
      OP_CMP, OP_CPX, OP_CPY: exe_op = ALU_CMP;
      OP_INX, OP_INY:         exe_op = ALU_INC;
      OP_DEX, OP_DEY:         exe_op = ALU_DEC;
      default:                exe_op = ALU_THA;
    endcase
    // Index ops and index compares work on X or Y, everything else on A
    case (op)
      OP_CPX, OP_INX, OP_DEX: exe_src_a = ALU_SRC_A_X;
      OP_CPY, OP_INY, OP_DEY: exe_src_a = ALU_SRC_A_Y;
      default:                exe_src_a = ALU_SRC_A_A;
    endcase
  end

  always_comb begin
    case (op)
      OP_CLC, OP_SEC: flag_mask = 8'b1 << FLAG_C;
      OP_CLD, OP_SED: flag_mask = 8'b1 << FLAG_D;
      OP_CLI, OP_SEI: flag_mask = 8'b1 << FLAG_I;
      OP_CLV:         flag_mask = 8'b1 << FLAG_V;
      default:        flag_mask = 8'h00;
    endcase
  end

  always_comb begin
    case (op)
      OP_BCC:  branch_taken = !flags[FLAG_C];
      OP_BCS:  branch_taken = flags[FLAG_C];
      OP_BNE:  branch_taken = !flags[FLAG_Z];
      OP_BEQ:  branch_taken = flags[FLAG_Z];
      OP_BVC:  branch_taken = !flags[FLAG_V];
      OP_BVS:  branch_taken = flags[FLAG_V];
      OP_BPL:  branch_taken = !flags[FLAG_N];
      OP_BMI:  branch_taken = flags[FLAG_N];
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// File: seq_fsm.sv
`timescale 1ns/1ps

module seq_fsm import cpu_ctrl_pkg::*; (
  input  logic      CLK,
  input  logic      rst_n,
  input  logic      rdy,
  input  decoded_t  dec,
  input  op_class_t cls,
  input  logic      branch_taken,
  input  logic      pc_carry,
  output state_t    state
);

  state_t next_state;

  // State only moves on a ready cycle
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n)
      state <= T0_R_OPCO;
    else if (rdy)
      state <= next_state;
  end

  always_comb begin
    case (state)
      T0_R_OPCO: next_state = T1_R_OPER;
      T1_R_OPER: begin
        case (dec.addr_mode)
          AM_ABS:         next_state = T2_ABS_AM;
          AM_ZPX, AM_ZPY: next_state = T2_ZPR_AM;
          AM_ZPG:         next_state = cls.is_str ? TX_W_DATA : TX_R_DATA;
          // Untaken branch goes straight to the dummy read
          AM_REL:         next_state = branch_taken ? T2_REL_AM : TX_R_DATA;
          default:        next_state = T0_R_OPCO;
        endcase
      end
      T2_ABS_AM: begin
        if (dec.op == OP_JMP)
          next_state = T0_R_OPCO;
        else if (cls.is_str)
          next_state = TX_W_DATA;
        else
          next_state = TX_R_DATA;
      end
      T2_ZPR_AM: next_state = cls.is_str ? TX_W_DATA : TX_R_DATA;
      // Page crossing needs one more cycle for PCH
      T2_REL_AM: next_state = pc_carry ? T3_REL_AM : TX_R_DATA;
      T3_REL_AM: next_state = TX_R_DATA;
      TX_R_DATA: next_state = T0_R_OPCO;
      TX_W_DATA: next_state = T0_R_OPCO;
      default:   next_state = T0_R_OPCO;
    endcase
  end

endmodule

// File: ctrl_word_gen.sv
`timescale 1ns/1ps

module ctrl_word_gen import cpu_ctrl_pkg::*, cpu_ctrl_word_pkg::*; (
  input  state_t     state,
  input  decoded_t   dec,
  input  op_class_t  cls,
  input  reg_src_t   mov_src,
  input  reg_dst_t   mov_dst,
  input  alu_op_t    exe_op,
  input  alu_src_a_t exe_src_a,
  input  logic [7:0] flag_mask,
  input  logic       branch_taken,
  output ctrl_word_t ctrl
);

  always_comb begin
    // Idle word is a read with nothing latched and an empty status mask
    ctrl.bus.r_w = RW_R;
    ctrl.bus.db_out_src = DB_A;
    ctrl.ir_we = 1'b0;
    ctrl.rf = '{REG_SRC_MEM, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    ctrl.alu = '{ALU_THA, ALU_SRC_A_A, ALU_SRC_B_T};
    ctrl.p = '{P_SRC_ALU, 8'h00, 1'b1};
    ctrl.pc = '{PCADDER_NOP, PCL_SRC_MEM, PCH_SRC_MEM, 1'b0, 1'b0};
    ctrl.ab = '{ABL_SRC_PCN, ABH_SRC_PCN, 1'b0, 1'b0};

    case (state)
      T0_R_OPCO: begin
        ctrl.ir_we = 1'b1;
        ctrl.alu.alu_op = exe_op;
        ctrl.alu.src_a = exe_src_a;

        // Result of the previous instruction lands here under the old IR
        if (cls.is_ldr || cls.is_txr) begin
          ctrl.rf.reg_src = mov_src;
          ctrl.rf.a_we = (mov_dst == REG_DST_A);
          ctrl.rf.x_we = (mov_dst == REG_DST_X);
          ctrl.rf.y_we = (mov_dst == REG_DST_Y);
          ctrl.rf.s_we = (mov_dst == REG_DST_S);
        end else if (exe_op != ALU_THA) begin
          ctrl.rf.reg_src = REG_SRC_ALU;
          ctrl.rf.a_we = (exe_src_a == ALU_SRC_A_A);
          ctrl.rf.x_we = (exe_src_a == ALU_SRC_A_X);
          ctrl.rf.y_we = (exe_src_a == ALU_SRC_A_Y);
        end

        ctrl.p.p_mask = flag_mask;
        if (exe_op != ALU_THA)
          ctrl.p.p_src = P_SRC_ALU;
        else if (cls.is_set)
          ctrl.p.p_src = P_SRC_SET;
        else if (cls.is_clr)
          ctrl.p.p_src = P_SRC_CLR;
        else
          ctrl.p.p_we = 1'b0;

        ctrl.pc = '{PCADDER_INC, PCL_SRC_ADD, PCH_SRC_ADD, 1'b1, 1'b1};
        ctrl.ab.abl_we = 1'b1;
        ctrl.ab.abh_we = 1'b1;
      end
      T1_R_OPER: begin
        // Operand byte goes to T
        ctrl.rf.reg_src = REG_SRC_MEM;
        ctrl.rf.t_we = 1'b1;

        if (dec.addr_mode == AM_IMP)
          ctrl.pc.pcadder = PCADDER_NOP;
        else if (dec.addr_mode == AM_REL && branch_taken)
          ctrl.pc.pcadder = PCADDER_ADD;
        else
          ctrl.pc.pcadder = PCADDER_INC;
        ctrl.pc.pcl_src = PCL_SRC_ADD;
        ctrl.pc.pch_src = PCH_SRC_ADD;
        ctrl.pc.pcl_we = 1'b1;
        ctrl.pc.pch_we = 1'b1;

        // Zero page modes point the bus at page 0
        if (dec.addr_mode inside {AM_ZPG, AM_ZPX, AM_ZPY}) begin
          ctrl.ab.abl_src = ABL_SRC_MEM;
          ctrl.ab.abh_src = ABH_SRC_H00;
        end
        ctrl.ab.abl_we = 1'b1;
        ctrl.ab.abh_we = 1'b1;
      end
      T2_ABS_AM: begin
        if (dec.op == OP_JMP)
          ctrl.pc = '{PCADDER_INC, PCL_SRC_T, PCH_SRC_MEM, 1'b1, 1'b1};
        else
          ctrl.pc = '{PCADDER_INC, PCL_SRC_ADD, PCH_SRC_ADD, 1'b1, 1'b1};
        // ADH from memory and ADL from T
        ctrl.ab = '{ABL_SRC_T, ABH_SRC_MEM, 1'b1, 1'b1};
      end
      T2_ZPR_AM: begin
        // Base address plus index wraps within page 0
        ctrl.alu.alu_op = ALU_ADC;
        ctrl.alu.src_a = (dec.addr_mode == AM_ZPX) ? ALU_SRC_A_X : ALU_SRC_A_Y;
        ctrl.ab.abl_src = ABL_SRC_ALU;
        ctrl.ab.abl_we = 1'b1;
      end
      T2_REL_AM: begin
        ctrl.pc = '{PCADDER_CADD, PCL_SRC_ADD, PCH_SRC_ADD, 1'b1, 1'b1};
        ctrl.ab.abl_we = 1'b1;
        ctrl.ab.abh_we = 1'b1;
      end
      T3_REL_AM: begin
        // Reload the bus from the PC with the corrected high byte
        ctrl.ab.abl_we = 1'b1;
        ctrl.ab.abh_we = 1'b1;
      end
      TX_R_DATA: begin
        ctrl.rf.reg_src = REG_SRC_MEM;
        ctrl.rf.t_we = 1'b1;
        ctrl.ab = '{ABL_SRC_PCC, ABH_SRC_PCC, 1'b1, 1'b1};
      end
      TX_W_DATA: begin
        ctrl.bus.r_w = RW_W;
        case (dec.op)
          OP_STX:  ctrl.bus.db_out_src = DB_X;
          OP_STY:  ctrl.bus.db_out_src = DB_Y;
          default: ctrl.bus.db_out_src = DB_A;
        endcase
        ctrl.ab = '{ABL_SRC_PCC, ABH_SRC_PCC, 1'b1, 1'b1};
      end
    endcase
  end

endmodule

// File: cpu_controller.sv
`timescale 1ns/1ps

module cpu_controller import cpu_ctrl_pkg::*, cpu_ctrl_word_pkg::*; (
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       rdy,
  input  logic [8:0] flags,
  input  logic [7:0] instr,
  output ctrl_word_t ctrl
);

  decoded_t   dec;
  op_class_t  cls;
  reg_src_t   mov_src;
  reg_dst_t   mov_dst;
  alu_op_t    exe_op;
  alu_src_a_t exe_src_a;
  logic [7:0] flag_mask;
  logic       branch_taken;
  state_t     state;

  instr_decoder u_instr_decoder (
    .instr (instr),
    .dec   (dec)
  );

  op_classifier u_op_classifier (
    .dec          (dec),
    .flags        (flags),
    .cls          (cls),
    .mov_src      (mov_src),
    .mov_dst      (mov_dst),
    .exe_op       (exe_op),
    .exe_src_a    (exe_src_a),
    .flag_mask    (flag_mask),
    .branch_taken (branch_taken)
  );

  seq_fsm u_seq_fsm (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .rdy          (rdy),
    .dec          (dec),
    .cls          (cls),
    .branch_taken (branch_taken),
    .pc_carry     (flags[FLAG_PCC]),
    .state        (state)
  );

  ctrl_word_gen u_ctrl_word_gen (
    .state        (state),
    .dec          (dec),
    .cls          (cls),
    .mov_src      (mov_src),
    .mov_dst      (mov_dst),
    .exe_op       (exe_op),
    .exe_src_a    (exe_src_a),
    .flag_mask    (flag_mask),
    .branch_taken (branch_taken),
    .ctrl         (ctrl)
  );

endmodule

// File: cpu_controller_asserts.sv
`timescale 1ns/1ps

module cpu_controller_asserts import cpu_ctrl_word_pkg::*; (
  input logic       CLK,
  input logic       rst_n,
  input logic       rdy,
  input ctrl_word_t ctrl
);

  logic [2:0]  ready_run;
  int unsigned fail_count = 0;

  // Ready cycles since the last ready fetch with the fetch itself counted
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n)
      ready_run <= 3'd0;
    else if (rdy)
      ready_run <= ctrl.ir_we ? 3'd1 : ready_run + 3'd1;
  end

  one_reg_write: assert property (@(posedge CLK) disable iff (!rst_n)
    $onehot0({ctrl.rf.a_we, ctrl.rf.x_we, ctrl.rf.y_we, ctrl.rf.s_we}))
    else begin
      $error("more than one register write enable is high");
      fail_count++;
    end

  no_write_on_fetch: assert property (@(posedge CLK) disable iff (!rst_n)
    !(ctrl.ir_we && ctrl.bus.r_w == RW_W))
    else begin
      $error("bus write coincides with an opcode fetch");
      fail_count++;
    end

  // Longest instruction is 5 ready cycles
  fetch_within_five: assert property (@(posedge CLK) disable iff (!rst_n)
    ready_run <= 3'd5)
    else begin
      $error("no opcode fetch within 5 ready cycles");
      fail_count++;
    end

endmodule

// File: tb_cpu_controller.sv
`timescale 1ns/1ps

module tb_cpu_controller import cpu_ctrl_pkg::*, cpu_ctrl_word_pkg::*; ();

  localparam int NUM_INSTR = 400;
  // Up to 5 cycles per instruction and twice that for rdy stalls
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 5 * 2 + 200;
  localparam int NUM_OPCODES = 77;

  // Opcode byte, operation, addressing mode
  localparam logic [17:0] OPCODES [NUM_OPCODES] = '{
    {8'h09, OP_ORA, AM_IMM}, {8'h05, OP_ORA, AM_ZPG}, {8'h15, OP_ORA, AM_ZPX},
    {8'h0D, OP_ORA, AM_ABS}, {8'h29, OP_AND, AM_IMM}, {8'h25, OP_AND, AM_ZPG},
    {8'h35, OP_AND, AM_ZPX}, {8'h2D, OP_AND, AM_ABS}, {8'h49, OP_EOR, AM_IMM},
    {8'h45, OP_EOR, AM_ZPG}, {8'h55, OP_EOR, AM_ZPX}, {8'h4D, OP_EOR, AM_ABS},
    {8'h69, OP_ADC, AM_IMM}, {8'h65, OP_ADC, AM_ZPG}, {8'h75, OP_ADC, AM_ZPX},
    {8'h6D, OP_ADC, AM_ABS}, {8'hE9, OP_SBC, AM_IMM}, {8'hE5, OP_SBC, AM_ZPG},
    {8'hF5, OP_SBC, AM_ZPX}, {8'hED, OP_SBC, AM_ABS}, {8'hC9, OP_CMP, AM_IMM},
    {8'hC5, OP_CMP, AM_ZPG}, {8'hD5, OP_CMP, AM_ZPX}, {8'hCD, OP_CMP, AM_ABS},
    {8'hA9, OP_LDA, AM_IMM}, {8'hA5, OP_LDA, AM_ZPG}, {8'hB5, OP_LDA, AM_ZPX},
    {8'hAD, OP_LDA, AM_ABS}, {8'hA2, OP_LDX, AM_IMM}, {8'hA6, OP_LDX, AM_ZPG},
    {8'hB6, OP_LDX, AM_ZPY}, {8'hAE, OP_LDX, AM_ABS}, {8'hA0, OP_LDY, AM_IMM},
    {8'hA4, OP_LDY, AM_ZPG}, {8'hB4, OP_LDY, AM_ZPX}, {8'hAC, OP_LDY, AM_ABS},
    {8'h85, OP_STA, AM_ZPG}, {8'h95, OP_STA, AM_ZPX}, {8'h8D, OP_STA, AM_ABS},
    {8'h86, OP_STX, AM_ZPG}, {8'h96, OP_STX, AM_ZPY}, {8'h8E, OP_STX, AM_ABS},
    {8'h84, OP_STY, AM_ZPG}, {8'h94, OP_STY, AM_ZPX}, {8'h8C, OP_STY, AM_ABS},
    {8'hE0, OP_CPX, AM_IMM}, {8'hE4, OP_CPX, AM_ZPG}, {8'hEC, OP_CPX, AM_ABS},
    {8'hC0, OP_CPY, AM_IMM}, {8'hC4, OP_CPY, AM_ZPG}, {8'hCC, OP_CPY, AM_ABS},
    {8'hE8, OP_INX, AM_IMP}, {8'hC8, OP_INY, AM_IMP}, {8'hCA, OP_DEX, AM_IMP},
    {8'h88, OP_DEY, AM_IMP}, {8'hAA, OP_TAX, AM_IMP}, {8'hA8, OP_TAY, AM_IMP},
    {8'h8A, OP_TXA, AM_IMP}, {8'h98, OP_TYA, AM_IMP}, {8'hBA, OP_TSX, AM_IMP},
    {8'h9A, OP_TXS, AM_IMP}, {8'h38, OP_SEC, AM_IMP}, {8'hF8, OP_SED, AM_IMP},
    {8'h78, OP_SEI, AM_IMP}, {8'h18, OP_CLC, AM_IMP}, {8'hD8, OP_CLD, AM_IMP},
    {8'h58, OP_CLI, AM_IMP}, {8'hB8, OP_CLV, AM_IMP}, {8'h90, OP_BCC, AM_REL},
    {8'hB0, OP_BCS, AM_REL}, {8'hD0, OP_BNE, AM_REL}, {8'hF0, OP_BEQ, AM_REL},
    {8'h50, OP_BVC, AM_REL}, {8'h70, OP_BVS, AM_REL}, {8'h10, OP_BPL, AM_REL},
    {8'h30, OP_BMI, AM_REL}, {8'h4C, OP_JMP, AM_ABS}
  };

  logic       CLK;
  logic       rst_n;
  logic       rdy;
  logic [8:0] flags;
  logic [7:0] instr;
  ctrl_word_t ctrl;

  // Reference model state
  state_t      m_state;
  op_t         cur_op;
  addr_mode_t  cur_mode;
  ctrl_word_t  prev_ctrl;
  logic        last_rdy;
  logic        load_next;
  logic        started;
  logic        taken;
  logic        page_cross;
  int          ready_cycles;
  int          writes;
  int          issued;
  int          cycle_count = 0;
  int unsigned checks_failed = 0;
  logic [17:0] entry;

  cpu_controller u_cpu_controller (
    .CLK   (CLK),
    .rst_n (rst_n),
    .rdy   (rdy),
    .flags (flags),
    .instr (instr),
    .ctrl  (ctrl)
  );

  bind cpu_controller cpu_controller_asserts u_cpu_controller_asserts (
    .CLK   (CLK),
    .rst_n (rst_n),
    .rdy   (rdy),
    .ctrl  (ctrl)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic fail_run(input string reason);
    checks_failed++;
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_field(input string name, input logic [47:0] expected,
                             input logic [47:0] actual);
    assert (actual === expected)
    else fail_run($sformatf("[FAIL] %s expected %0h actual %0h", name, expected, actual));
  endtask

  function automatic logic is_store(input op_t op);
    return op inside {OP_STA, OP_STX, OP_STY};
  endfunction

  function automatic logic is_alu(input op_t op);
    return op inside {OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR, OP_CMP, OP_CPX, OP_CPY,
                      OP_INX, OP_INY, OP_DEX, OP_DEY};
  endfunction

  function automatic logic is_set_op(input op_t op);
    return op inside {OP_SEC, OP_SED, OP_SEI};
  endfunction

  // Status bit touched by a flag instruction
  function automatic logic [7:0] flag_bit(input op_t op);
    case (op)
      OP_SEC, OP_CLC: return 8'h01;
      OP_SEI, OP_CLI: return 8'h04;
      OP_SED, OP_CLD: return 8'h08;
      OP_CLV:         return 8'h40;
      default:        return 8'h00;
    endcase
  endfunction

  function automatic logic branch_cond(input op_t op, input logic [8:0] fl);
    case (op)
      OP_BCC:  return !fl[FLAG_C];
      OP_BCS:  return fl[FLAG_C];
      OP_BNE:  return !fl[FLAG_Z];
      OP_BEQ:  return fl[FLAG_Z];
      OP_BVC:  return !fl[FLAG_V];
      OP_BVS:  return fl[FLAG_V];
      OP_BPL:  return !fl[FLAG_N];
      OP_BMI:  return fl[FLAG_N];
      default: return 1'b0;
    endcase
  endfunction

  // Register enables {a, x, y, s} in the write-back cycle
  function automatic logic [3:0] wb_enables(input op_t op);
    case (op)
      OP_LDA, OP_TXA, OP_TYA, OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR, OP_CMP:
        return 4'b1000;
      OP_LDX, OP_TAX, OP_TSX, OP_CPX, OP_INX, OP_DEX:
        return 4'b0100;
      OP_LDY, OP_TAY, OP_CPY, OP_INY, OP_DEY:
        return 4'b0010;
      OP_TXS:
        return 4'b0001;
      default:
        return 4'b0000;
    endcase
  endfunction

  function automatic reg_src_t wb_source(input op_t op);
    case (op)
      OP_LDA, OP_LDX, OP_LDY: return REG_SRC_T;
      OP_TAX, OP_TAY:         return REG_SRC_A;
      OP_TXA, OP_TXS:         return REG_SRC_X;
      OP_TYA:                 return REG_SRC_Y;
      OP_TSX:                 return REG_SRC_S;
      default:                return REG_SRC_ALU;
    endcase
  endfunction

  // Ready cycles per instruction with the fetch included
  function automatic int instr_length(input op_t op, input addr_mode_t mode,
                                      input logic tk, input logic pcc);
    case (mode)
      AM_ZPG:         return 3;
      AM_ZPX, AM_ZPY: return 4;
      AM_ABS:         return (op == OP_JMP) ? 3 : 4;
      AM_REL:         return !tk ? 3 : (pcc ? 5 : 4);
      default:        return 2;
    endcase
  endfunction

  function automatic state_t model_next(input state_t st, input op_t op,
                                        input addr_mode_t mode, input logic [8:0] fl);
    case (st)
      T0_R_OPCO: return T1_R_OPER;
      T1_R_OPER: begin
        case (mode)
          AM_ZPG:         return is_store(op) ? TX_W_DATA : TX_R_DATA;
          AM_ZPX, AM_ZPY: return T2_ZPR_AM;
          AM_ABS:         return T2_ABS_AM;
          AM_REL:         return branch_cond(op, fl) ? T2_REL_AM : TX_R_DATA;
          default:        return T0_R_OPCO;
        endcase
      end
      T2_ABS_AM: begin
        if (op == OP_JMP)
          return T0_R_OPCO;
        return is_store(op) ? TX_W_DATA : TX_R_DATA;
      end
      T2_ZPR_AM: return is_store(op) ? TX_W_DATA : TX_R_DATA;
      T2_REL_AM: return fl[FLAG_PCC] ? T3_REL_AM : TX_R_DATA;
      T3_REL_AM: return TX_R_DATA;
      default:   return T0_R_OPCO;
    endcase
  endfunction

  task automatic check_cycle();
    ctrl_word_t  c;
    logic [3:0]  we;
    pcadder_t    exp_pcadder;
    db_out_src_t exp_db;
    c = ctrl;
    we = {c.rf.a_we, c.rf.x_we, c.rf.y_we, c.rf.s_we};
    // Nothing moved while stalled
    if (!last_rdy)
      check_field("ctrl", prev_ctrl, c);
    check_field("ir_we", m_state == T0_R_OPCO, c.ir_we);
    check_field("r_w", (m_state == TX_W_DATA) ? RW_W : RW_R, c.bus.r_w);
    case (m_state)
      T0_R_OPCO: begin
        check_field("reg_we", wb_enables(cur_op), we);
        if (wb_enables(cur_op) != 4'b0000)
          check_field("reg_src", wb_source(cur_op), c.rf.reg_src);
        check_field("p_we", is_alu(cur_op) || flag_bit(cur_op) != 8'h00, c.p.p_we);
        if (is_alu(cur_op))
          check_field("p_src", P_SRC_ALU, c.p.p_src);
        if (flag_bit(cur_op) != 8'h00) begin
          check_field("p_src", is_set_op(cur_op) ? P_SRC_SET : P_SRC_CLR, c.p.p_src);
          check_field("p_mask", flag_bit(cur_op), c.p.p_mask);
        end
      end
      T1_R_OPER: begin
        if (cur_mode == AM_IMP)
          exp_pcadder = PCADDER_NOP;
        else if (cur_mode == AM_REL && branch_cond(cur_op, flags))
          exp_pcadder = PCADDER_ADD;
        else
          exp_pcadder = PCADDER_INC;
        check_field("pcadder", exp_pcadder, c.pc.pcadder);
      end
      T2_ABS_AM: begin
        if (cur_op == OP_JMP) begin
          check_field("pcl_src", PCL_SRC_T, c.pc.pcl_src);
          check_field("pch_src", PCH_SRC_MEM, c.pc.pch_src);
        end
      end
      TX_W_DATA: begin
        if (cur_op == OP_STX)
          exp_db = DB_X;
        else if (cur_op == OP_STY)
          exp_db = DB_Y;
        else
          exp_db = DB_A;
        check_field("db_out_src", exp_db, c.bus.db_out_src);
      end
      default: begin
      end
    endcase
    if (m_state != T0_R_OPCO)
      check_field("reg_we", 4'b0000, we);
  endtask

  // Length and store counts are closed at each ready fetch
  task automatic track_ready_cycle();
    if (ctrl.ir_we) begin
      if (started) begin
        check_field("instr_length", instr_length(cur_op, cur_mode, taken, page_cross),
                    ready_cycles);
        check_field("write_cycles", is_store(cur_op), writes);
      end
      started = 1'b1;
      ready_cycles = 0;
      writes = 0;
      taken = 1'b0;
      page_cross = 1'b0;
    end
    ready_cycles++;
    if (ctrl.bus.r_w == RW_W)
      writes++;
    if (m_state == T1_R_OPER)
      taken = branch_cond(cur_op, flags);
    if (m_state == T2_REL_AM)
      page_cross = flags[FLAG_PCC];
    m_state = model_next(m_state, cur_op, cur_mode, flags);
  endtask

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES)
      fail_run("Timeout: the instruction stream did not finish in time");
  end

  always @(negedge CLK) begin
    if (u_cpu_controller.u_cpu_controller_asserts.fail_count != 0)
      fail_run("A bound assertion on the control word failed");
  end

  initial begin
    void'($urandom(32'h2028));
    rst_n = 1'b0;
    rdy = 1'b0;
    flags = 9'h000;
    instr = 8'hEA;
    cur_op = OP_NOP;
    cur_mode = AM_IMP;
    m_state = T0_R_OPCO;
    prev_ctrl = '0;
    last_rdy = 1'b1;
    load_next = 1'b0;
    started = 1'b0;
    taken = 1'b0;
    page_cross = 1'b0;
    ready_cycles = 0;
    writes = 0;
    issued = 0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;

    while (!(load_next && issued == NUM_INSTR)) begin
      // New opcode only after the IR has loaded
      if (load_next) begin
        entry = OPCODES[$urandom_range(NUM_OPCODES - 1, 0)];
        instr = entry[17:10];
        cur_op = op_t'(entry[9:4]);
        cur_mode = addr_mode_t'(entry[3:0]);
        issued++;
      end
      if (last_rdy)
        flags = 9'($urandom_range(511, 0));
      rdy = ($urandom_range(4, 0) != 0);
      #1;
      check_cycle();
      load_next = rdy && (m_state == T0_R_OPCO);
      prev_ctrl = ctrl;
      last_rdy = rdy;
      if (rdy)
        track_ready_cycle();
      @(negedge CLK);
    end

    if (checks_failed == 0 &&
        u_cpu_controller.u_cpu_controller_asserts.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
cpu_ctrl_pkg.sv
cpu_ctrl_word_pkg.sv
instr_decoder.sv
op_classifier.sv
seq_fsm.sv
ctrl_word_gen.sv
cpu_controller.sv
cpu_controller_asserts.sv
tb_cpu_controller.sv
